// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ns --top-module alu_tb -f sources.f -o alu_sim

output=$(./obj_dir/alu_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -q "Finished with no errors"; then
  exit 0
else
  exit 1
fi

// File: source/add_sub_unit.sv
`timescale 1ns/1ns
`default_nettype none
`include "alu_macros.svh"

module add_sub_unit (
  input wire alu_pkg::aluOp_e op,
  input wire [`DATA_WIDTH-1:0] a,
  input wire [`DATA_WIDTH-1:0] b,
  input wire carryIn,
  input wire [`DATA_WIDTH-1:0] cbzValue,
  output alu_pkg::unitOut_t out
);
  import alu_pkg::*;

  localparam logic [`DATA_WIDTH-1:0] SatMax = {1'b0, {(`DATA_WIDTH-1){1'b1}}};
  localparam logic [`DATA_WIDTH-1:0] SatMin = {1'b1, {(`DATA_WIDTH-1){1'b0}}};

  logic [`DATA_WIDTH-1:0] opX;
  logic [`DATA_WIDTH-1:0] opY;
  logic cin;
  logic takeBranch;
  logic [`DATA_WIDTH:0] sum;
  logic signedOvf;
  logic isSat;

  assign takeBranch = (op == OP_CBZ) ? (cbzValue == '0) : (cbzValue != '0);

  // Subtraction as a + ~b + 1, operands swapped for RSB
  always_comb begin
    opX = a;
    opY = b;
    cin = 1'b0;
    case (op)
      OP_ADC: cin = carryIn;
      OP_SUB, OP_CMP, OP_QSUB: begin
        opY = ~b;
        cin = 1'b1;
      end
      OP_SBC: begin
        opY = ~b;
        cin = carryIn;
      end
      OP_RSB: begin
        opX = b;
        opY = ~a;
        cin = 1'b1;
      end
      OP_CBZ, OP_CBNZ: opY = takeBranch ? b : '0;
      default: ;
    endcase
  end

  assign sum = {1'b0, opX} + {1'b0, opY} + (`DATA_WIDTH+1)'(cin);

  // Same operand signs but result sign differs
  assign signedOvf = (opX[`DATA_WIDTH-1] == opY[`DATA_WIDTH-1]) &&
                     (sum[`DATA_WIDTH-1] != opX[`DATA_WIDTH-1]);
  assign isSat = (op == OP_QADD || op == OP_QSUB) && signedOvf;

  always_comb begin
    out = '0;
    out.value.halves.lo = isSat ? (opX[`DATA_WIDTH-1] ? SatMin : SatMax)
                                : sum[`DATA_WIDTH-1:0];
    out.saturated = isSat;
    case (op)
      OP_ADD, OP_ADC, OP_CMN, OP_SUB, OP_SBC, OP_CMP, OP_RSB: begin
        out.carry = sum[`DATA_WIDTH];
        out.overflow = signedOvf;
      end
      OP_QADD, OP_QSUB: out.overflow = signedOvf;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: source/alu_control.sv
`timescale 1ns/1ns
`default_nettype none
`include "alu_macros.svh"

module alu_control (
  input wire clk,
  input wire rst,
  input wire start,
  input wire alu_pkg::aluOp_e op,
  input wire alu_pkg::unitOut_t addOut,
  input wire alu_pkg::unitOut_t logicOut,
  input wire alu_pkg::unitOut_t macOut,
  input wire alu_pkg::unitOut_t divOut,
  input wire divDone,
  output logic divStart,
  output logic divSigned,
  output logic busy,
  output logic done,
  output alu_pkg::aluWide_u result,
  output alu_pkg::aluFlags_t flags
);
  import alu_pkg::*;

  localparam logic [1:0] UnitAdd = 2'd0;
  localparam logic [1:0] UnitLogic = 2'd1;
  localparam logic [1:0] UnitMac = 2'd2;
  localparam logic [1:0] UnitDiv = 2'd3;

  logic [1:0] unitSel;
  logic longOp;
  logic selLong;
  logic capture;
  unitOut_t selOut;
  aluFlags_t nextFlags;

  // Unit class per operation
  always_comb begin
    unitSel = UnitLogic;
    longOp = 1'b0;
    case (op)
      OP_ADD, OP_ADC, OP_QADD, OP_SUB, OP_SBC, OP_RSB, OP_QSUB,
      OP_CMN, OP_CMP, OP_B, OP_CBZ, OP_CBNZ: unitSel = UnitAdd;
      OP_MUL, OP_MLA, OP_MLS: unitSel = UnitMac;
      OP_UMULL, OP_UMLAL, OP_SMULL, OP_SMLAL: begin
        unitSel = UnitMac;
        longOp = 1'b1;
      end
      OP_UDIV, OP_SDIV: unitSel = UnitDiv;
      default: unitSel = UnitLogic;
    endcase
  end

  assign divStart = start && !busy && (unitSel == UnitDiv);
  assign divSigned = (op == OP_SDIV);

  // While busy only a division can be in flight
  always_comb begin
    if (busy) begin
      selOut = divOut;
    end else begin
      case (unitSel)
        UnitAdd: selOut = addOut;
        UnitLogic: selOut = logicOut;
        UnitMac: selOut = macOut;
        default: selOut = divOut;
      endcase
    end
  end

  assign selLong = longOp && !busy;
  assign capture = busy ? divDone : (start && unitSel != UnitDiv);

  always_comb begin
    nextFlags.saturated = selOut.saturated;
    nextFlags.negative = selLong ? selOut.value.wide[2*`DATA_WIDTH-1]
                                 : selOut.value.halves.lo[`DATA_WIDTH-1];
    nextFlags.zero = selLong ? (selOut.value.wide == '0) : (selOut.value.halves.lo == '0);
    nextFlags.carry = selOut.carry;
    nextFlags.overflow = selOut.overflow;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      done <= 1'b0;
      result <= '0;
      flags <= '0;
    end else begin
      done <= capture;
      if (divStart) begin
        busy <= 1'b1;
      end else if (busy && divDone) begin
        busy <= 1'b0;
      end
      // Outputs hold until the next completion
      if (capture) begin
        result <= selOut.value;
        flags <= nextFlags;
      end
    end
  end

  noStartWhileBusy: assert property (@(posedge clk) disable iff (rst) busy |-> !start);
  divDoneOnlyWhileBusy: assert property (@(posedge clk) disable iff (rst) divDone |-> busy);
  doneNotWithStart: assert property (@(posedge clk) disable iff (rst) done |-> !start);

endmodule

`default_nettype wire

// File: source/alu_macros.svh
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// Operand and accumulator word width
`define DATA_WIDTH 32

// Operation code width
`define OP_WIDTH 6

// One quotient bit per divider iteration
`define DIV_STEPS `DATA_WIDTH

`endif

// File: source/alu_pkg.sv
`default_nettype none
`include "alu_macros.svh"

package alu_pkg;

  // Encodings follow the existing core decoder
  typedef enum logic [`OP_WIDTH-1:0] {
    OP_ADD   = 6'b100000, OP_ADC   = 6'b100001, OP_QADD  = 6'b100010,
    OP_SUB   = 6'b100011, OP_SBC   = 6'b100100, OP_RSB   = 6'b100101,
    OP_QSUB  = 6'b100110,
    OP_MUL   = 6'b100111, OP_MLA   = 6'b101000, OP_MLS   = 6'b101001,
    OP_UMULL = 6'b101010, OP_UMLAL = 6'b101011, OP_SMULL = 6'b101100,
    OP_SMLAL = 6'b101101,
    OP_UDIV  = 6'b101110, OP_SDIV  = 6'b101111,
    OP_AND   = 6'b110000, OP_BIC   = 6'b110001, OP_ORR   = 6'b110010,
    OP_ORN   = 6'b110011, OP_EOR   = 6'b110100,
    OP_CMN   = 6'b110101, OP_TST   = 6'b110110, OP_TEQ   = 6'b110111,
    OP_CMP   = 6'b111000, OP_MOV   = 6'b111001,
    OP_LSR   = 6'b111010, OP_ASR   = 6'b111011, OP_LSL   = 6'b111100,
    OP_ROR   = 6'b111101, OP_RRX   = 6'b111110, OP_EON   = 6'b111111,
    OP_B     = 6'b010000, OP_CBZ   = 6'b010010, OP_CBNZ  = 6'b010011
  } aluOp_e;

  typedef struct packed {
    aluOp_e                 op;
    logic [`DATA_WIDTH-1:0] a;
    logic [`DATA_WIDTH-1:0] b;
    logic [`DATA_WIDTH-1:0] accLo;
    logic [`DATA_WIDTH-1:0] accHi;
    logic                   carryIn;
    logic [`DATA_WIDTH-1:0] cbzValue;
  } aluReq_t;

  typedef struct packed {
    logic saturated;
    logic negative;
    logic zero;
    logic carry;
    logic overflow;
  } aluFlags_t;

  // Long multiplies use wide, 32-bit units fill halves
  typedef union packed {
    logic [2*`DATA_WIDTH-1:0] wide;
    struct packed {
      logic [`DATA_WIDTH-1:0] hi;
      logic [`DATA_WIDTH-1:0] lo;
    } halves;
  } aluWide_u;

  typedef struct packed {
    aluWide_u value;
    logic     carry;
    logic     overflow;
    logic     saturated;
  } unitOut_t;

endpackage

`default_nettype wire

// File: source/alu_top.sv
`timescale 1ns/1ns
`default_nettype none

module alu_top (
  input wire clk,
  input wire rst,
  input wire start,
  input wire alu_pkg::aluReq_t req,
  output logic busy,
  output logic done,
  output alu_pkg::aluWide_u result,
  output alu_pkg::aluFlags_t flags
);
  import alu_pkg::*;

  unitOut_t addOut;
  unitOut_t logicOut;
  unitOut_t macOut;
  unitOut_t divOut;
  logic divStart;
  logic divSigned;
  logic divDone;

  alu_control control_i (
    .clk(clk),
    .rst(rst),
    .start(start),
    .op(req.op),
    .addOut(addOut),
    .logicOut(logicOut),
    .macOut(macOut),
    .divOut(divOut),
    .divDone(divDone),
    .divStart(divStart),
    .divSigned(divSigned),
    .busy(busy),
    .done(done),
    .result(result),
    .flags(flags)
  );

  add_sub_unit addSub_i (
    .op(req.op),
    .a(req.a),
    .b(req.b),
    .carryIn(req.carryIn),
    .cbzValue(req.cbzValue),
    .out(addOut)
  );

  logic_shift_unit logicShift_i (
    .op(req.op),
    .a(req.a),
    .b(req.b),
    .carryIn(req.carryIn),
    .out(logicOut)
  );

  mac_unit mac_i (
    .op(req.op),
    .a(req.a),
    .b(req.b),
    .accLo(req.accLo),
    .accHi(req.accHi),
    .out(macOut)
  );

  // Operands are sampled on the start cycle only
  div_unit div_i (
    .clk(clk),
    .rst(rst),
    .divStart(divStart),
    .divSigned(divSigned),
    .dividend(req.a),
    .divisor(req.b),
    .divDone(divDone),
    .out(divOut)
  );

endmodule

`default_nettype wire

// File: source/div_unit.sv
`timescale 1ns/1ns
`default_nettype none
`include "alu_macros.svh"

module div_unit (
  input wire clk,
  input wire rst,
  input wire divStart,
  input wire divSigned,
  input wire [`DATA_WIDTH-1:0] dividend,
  input wire [`DATA_WIDTH-1:0] divisor,
  output logic divDone,
  output alu_pkg::unitOut_t out
);

  localparam int CountWidth = $clog2(`DIV_STEPS + 1);

  logic running;
  logic [CountWidth-1:0] count;
  logic [`DATA_WIDTH-1:0] dividendMag;
  logic [`DATA_WIDTH-1:0] divisorMag;
  logic [`DATA_WIDTH-1:0] quot;
  logic [`DATA_WIDTH-1:0] rem;
  logic [`DATA_WIDTH-1:0] dvs;
  logic negQ;
  logic zeroDiv;
  logic [`DATA_WIDTH+1:0] trial;

  assign dividendMag = (divSigned && dividend[`DATA_WIDTH-1]) ? -dividend : dividend;
  assign divisorMag = (divSigned && divisor[`DATA_WIDTH-1]) ? -divisor : divisor;

  // Shifted remainder minus divisor, negative means restore
  assign trial = {1'b0, rem, quot[`DATA_WIDTH-1]} - {2'b00, dvs};

  always_ff @(posedge clk) begin
    if (rst) begin
      running <= 1'b0;
      count <= '0;
      divDone <= 1'b0;
    end else begin
      divDone <= 1'b0;
      if (divStart) begin
        running <= 1'b1;
        count <= CountWidth'(`DIV_STEPS);
      end else if (running) begin
        count <= count - CountWidth'(1);
        if (count == CountWidth'(1)) begin
          running <= 1'b0;
          divDone <= 1'b1;
        end
      end
    end
  end

  // Quotient bits shift in where the dividend shifts out
  always_ff @(posedge clk) begin
    if (divStart) begin
      quot <= dividendMag;
      rem <= '0;
      dvs <= divisorMag;
      negQ <= divSigned && (dividend[`DATA_WIDTH-1] ^ divisor[`DATA_WIDTH-1]);
      zeroDiv <= (divisor == '0);
    end else if (running) begin
      quot <= {quot[`DATA_WIDTH-2:0], !trial[`DATA_WIDTH+1]};
      rem <= trial[`DATA_WIDTH+1] ? {rem[`DATA_WIDTH-2:0], quot[`DATA_WIDTH-1]}
                                  : trial[`DATA_WIDTH-1:0];
    end
  end

  // Sign fix gives truncation toward zero
  always_comb begin
    out = '0;
    if (!zeroDiv) begin
      out.value.halves.lo = negQ ? -quot : quot;
    end
  end

  noRestartWhileRunning: assert property (@(posedge clk) disable iff (rst)
    running |-> !divStart);

endmodule

`default_nettype wire

// File: source/logic_shift_unit.sv
`timescale 1ns/1ns
`default_nettype none
`include "alu_macros.svh"

module logic_shift_unit (
  input wire alu_pkg::aluOp_e op,
  input wire [`DATA_WIDTH-1:0] a,
  input wire [`DATA_WIDTH-1:0] b,
  input wire carryIn,
  output alu_pkg::unitOut_t out
);
  import alu_pkg::*;

  logic [4:0] shAmt;
  logic [`DATA_WIDTH:0] lslExt;
  logic [`DATA_WIDTH:0] lsrExt;
  logic [`DATA_WIDTH:0] asrExt;
  logic [2*`DATA_WIDTH-1:0] rorExt;

  assign shAmt = b[4:0];

  // One spare bit catches the last bit shifted out
  assign lslExt = {1'b0, a} << shAmt;
  assign lsrExt = {a, 1'b0} >> shAmt;
  assign asrExt = $signed({a, 1'b0}) >>> shAmt;
  assign rorExt = {a, a} >> shAmt;

  always_comb begin
    out = '0;
    case (op)
      OP_AND, OP_TST: out.value.halves.lo = a & b;
      OP_BIC: out.value.halves.lo = a & ~b;
      OP_ORR: out.value.halves.lo = a | b;
      OP_ORN: out.value.halves.lo = a | ~b;
      OP_EOR, OP_TEQ: out.value.halves.lo = a ^ b;
      OP_EON: out.value.halves.lo = ~(a ^ b);
      OP_MOV: out.value.halves.lo = b;
      OP_LSL: begin
        out.value.halves.lo = lslExt[`DATA_WIDTH-1:0];
        out.carry = lslExt[`DATA_WIDTH];
      end
      OP_LSR: begin
        out.value.halves.lo = lsrExt[`DATA_WIDTH:1];
        out.carry = lsrExt[0];
      end
      OP_ASR: begin
        out.value.halves.lo = asrExt[`DATA_WIDTH:1];
        out.carry = asrExt[0];
      end
      OP_ROR: out.value.halves.lo = rorExt[`DATA_WIDTH-1:0];
      OP_RRX: out.value.halves.lo = {carryIn, a[`DATA_WIDTH-1:1]};
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: source/mac_unit.sv
`timescale 1ns/1ns
`default_nettype none
`include "alu_macros.svh"

module mac_unit (
  input wire alu_pkg::aluOp_e op,
  input wire [`DATA_WIDTH-1:0] a,
  input wire [`DATA_WIDTH-1:0] b,
  input wire [`DATA_WIDTH-1:0] accLo,
  input wire [`DATA_WIDTH-1:0] accHi,
  output alu_pkg::unitOut_t out
);
  import alu_pkg::*;

  logic signedOp;
  logic signed [`DATA_WIDTH:0] aOp;
  logic signed [`DATA_WIDTH:0] bOp;
  logic [2*`DATA_WIDTH-1:0] product;

  // Extra top bit makes one signed multiplier serve both forms
  assign signedOp = (op == OP_SMULL) || (op == OP_SMLAL);
  assign aOp = {signedOp & a[`DATA_WIDTH-1], a};
  assign bOp = {signedOp & b[`DATA_WIDTH-1], b};
  assign product = (2*`DATA_WIDTH)'(aOp) * (2*`DATA_WIDTH)'(bOp);

  always_comb begin
    out = '0;
    case (op)
      OP_MUL: out.value.halves.lo = product[`DATA_WIDTH-1:0];
      OP_MLA: out.value.halves.lo = accHi + product[`DATA_WIDTH-1:0];
      OP_MLS: out.value.halves.lo = accHi - product[`DATA_WIDTH-1:0];
      OP_UMULL, OP_SMULL: out.value.wide = product;
      OP_UMLAL, OP_SMLAL: out.value.wide = product + {accHi, accLo};
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+source
source/alu_pkg.sv
source/alu_control.sv
source/add_sub_unit.sv
source/logic_shift_unit.sv
source/mac_unit.sv
source/div_unit.sv
source/alu_top.sv
test/alu_tb.sv

// File: test/alu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module alu_tb;
  import alu_pkg::*;

  localparam int TimeoutCycles = 100;
  localparam longint MaxSigned = 64'sd2147483647;
  localparam longint MinSigned = -64'sd2147483648;

  logic clk = 1'b0;
  logic rst;
  logic start;
  aluReq_t req;
  logic busy;
  logic done;
  aluWide_u result;
  aluFlags_t flags;

  logic [31:0] lfsrState;
  int errors;

  alu_top dut_i (
    .clk(clk),
    .rst(rst),
    .start(start),
    .req(req),
    .busy(busy),
    .done(done),
    .result(result),
    .flags(flags)
  );

  always #5 clk = ~clk;

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] w;
    logic fb;
    int i;
    w = '0;
    for (i = 0; i < n; i++) begin
      fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};
      w = {w[30:0], fb};
    end
    return w;
  endfunction

  task automatic checkEq(input string name, input logic [63:0] got,
                         input logic [63:0] expected);
    if (got !== expected) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
      $display("Finished with errors");
      $fatal(1, "Stopped at first error");
    end
  endtask

  function automatic logic outOfRange(input longint v);
    return (v > MaxSigned) || (v < MinSigned);
  endfunction

  function automatic aluReq_t makeReq(input aluOp_e op, input logic [31:0] a,
                                      input logic [31:0] b);
    aluReq_t r;
    r = '0;
    r.op = op;
    r.a = a;
    r.b = b;
    return r;
  endfunction

  // Reference model built from the result and flag rules
  task automatic modelOp(input aluReq_t r, output logic [63:0] res, output aluFlags_t f);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] lo;
    logic [31:0] tmp;
    longint sa;
    longint sb;
    longint ua;
    longint ub;
    longint exact;
    longint cin;
    logic longRes;
    int sh;
    a = r.a;
    b = r.b;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    ua = longint'(a);
    ub = longint'(b);
    sh = int'(b[4:0]);
    cin = 0;
    lo = '0;
    res = '0;
    longRes = 1'b0;
    f = '0;
    case (r.op)
      OP_ADD, OP_ADC, OP_CMN: begin
        if (r.op == OP_ADC) cin = longint'(r.carryIn);
        exact = sa + sb + cin;
        lo = exact[31:0];
        f.carry = (ua + ub + cin) > 64'hffffffff;
        f.overflow = outOfRange(exact);
      end
      OP_SUB, OP_SBC, OP_CMP: begin
        // Borrow is the inverted carry input for SBC
        if (r.op == OP_SBC) cin = longint'(!r.carryIn);
        exact = sa - sb - cin;
        lo = exact[31:0];
        f.carry = ua >= ub + cin;
        f.overflow = outOfRange(exact);
      end
      OP_RSB: begin
        exact = sb - sa;
        lo = exact[31:0];
        f.carry = ub >= ua;
        f.overflow = outOfRange(exact);
      end
      OP_QADD, OP_QSUB: begin
        exact = (r.op == OP_QADD) ? sa + sb : sa - sb;
        lo = exact[31:0];
        if (outOfRange(exact)) begin
          lo = (exact < 0) ? 32'h80000000 : 32'h7fffffff;
          f.saturated = 1'b1;
          f.overflow = 1'b1;
        end
      end
      OP_B: lo = a + b;
      OP_CBZ: lo = (r.cbzValue == '0) ? a + b : a;
      OP_CBNZ: lo = (r.cbzValue != '0) ? a + b : a;
      OP_AND, OP_TST: lo = a & b;
      OP_BIC: lo = a & ~b;
      OP_ORR: lo = a | b;
      OP_ORN: lo = a | ~b;
      OP_EOR, OP_TEQ: lo = a ^ b;
      OP_EON: lo = ~(a ^ b);
      OP_MOV: lo = b;
      OP_LSL: begin
        lo = a << sh;
        tmp = a >> (32 - sh);
        f.carry = (sh != 0) && tmp[0];
      end
      OP_LSR, OP_ASR: begin
        lo = (r.op == OP_ASR) ? 32'($signed(a) >>> sh) : a >> sh;
        tmp = a >> (sh - 1);
        f.carry = (sh != 0) && tmp[0];
      end
      OP_ROR: lo = (a >> sh) | (a << (32 - sh));
      OP_RRX: lo = {r.carryIn, a[31:1]};
      OP_MUL: lo = a * b;
      OP_MLA: lo = r.accHi + a * b;
      OP_MLS: lo = r.accHi - a * b;
      OP_UMULL: res = ua * ub;
      OP_UMLAL: res = ua * ub + {r.accHi, r.accLo};
      OP_SMULL: res = sa * sb;
      OP_SMLAL: res = sa * sb + {r.accHi, r.accLo};
      OP_UDIV: lo = (b == '0) ? '0 : a / b;
      OP_SDIV: begin
        // Integer division truncates toward zero
        exact = (b == '0) ? 0 : sa / sb;
        lo = exact[31:0];
      end
      default: lo = '0;
    endcase
    longRes = (r.op == OP_UMULL) || (r.op == OP_UMLAL) ||
              (r.op == OP_SMULL) || (r.op == OP_SMLAL);
    if (!longRes) res = {32'h0, lo};
    f.negative = longRes ? res[63] : lo[31];
    f.zero = longRes ? (res == '0) : (lo == '0);
  endtask

  // Starts one request, waits for done, then checks outputs and hold
  task automatic runOp(input aluReq_t r);
    logic [63:0] expRes;
    aluFlags_t expFlags;
    logic isDiv;
    int waited;
    modelOp(r, expRes, expFlags);
    isDiv = (r.op == OP_UDIV) || (r.op == OP_SDIV);
    req = r;
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    waited = 0;
    while (!done) begin
      if (isDiv) checkEq("busy", 64'(busy), 64'(1));
      if (waited >= TimeoutCycles) begin
        errors++;
        $display("Timeout: done never came for %s", r.op.name());
        $display("Finished with errors");
        $fatal(1, "No done from the DUT");
      end else begin
        @(posedge clk);
        #1;
        waited++;
      end
    end
    if (!isDiv) checkEq("latency", 64'(waited), 64'(0));
    checkEq("busy", 64'(busy), 64'(0));
    checkEq("result", result.wide, expRes);
    checkEq("flags.saturated", 64'(flags.saturated), 64'(expFlags.saturated));
    checkEq("flags.negative", 64'(flags.negative), 64'(expFlags.negative));
    checkEq("flags.zero", 64'(flags.zero), 64'(expFlags.zero));
    checkEq("flags.carry", 64'(flags.carry), 64'(expFlags.carry));
    checkEq("flags.overflow", 64'(flags.overflow), 64'(expFlags.overflow));
    // New operands must not disturb the registered output
    req.a = ~r.a;
    @(posedge clk);
    #1;
    checkEq("done", 64'(done), 64'(0));
    checkEq("result held", result.wide, expRes);
    checkEq("flags held", 64'(flags), 64'(expFlags));
  endtask

  task automatic resetTest();
    checkEq("busy", 64'(busy), 64'(0));
    checkEq("done", 64'(done), 64'(0));
    checkEq("result", result.wide, 64'(0));
    checkEq("flags", 64'(flags), 64'(0));
    runOp(makeReq(OP_ADD, 32'h1, 32'h2));
  endtask

  task automatic addSubTest();
    aluOp_e ops[10] = '{OP_ADD, OP_ADC, OP_SUB, OP_SBC, OP_RSB,
                        OP_CMP, OP_CMN, OP_B, OP_CBZ, OP_CBNZ};
    aluReq_t r;
    logic [31:0] bit1;
    int i;
    int k;
    for (i = 0; i < 10; i++) begin
      for (k = 0; k < 6; k++) begin
        r = makeReq(ops[i], randBits(32), randBits(32));
        bit1 = randBits(1);
        r.carryIn = bit1[0];
        r.cbzValue = k[0] ? (randBits(32) | 32'h1) : '0;
        runOp(r);
      end
    end
    runOp(makeReq(OP_SUB, 32'h1234, 32'h1234));
    runOp(makeReq(OP_ADD, 32'h7fffffff, 32'h1));
    runOp(makeReq(OP_CMN, 32'hffffffff, 32'h1));
  endtask

  task automatic satTest();
    int i;
    runOp(makeReq(OP_QADD, 32'h7fffffff, 32'h1));
    runOp(makeReq(OP_QSUB, 32'h80000000, 32'h1));
    runOp(makeReq(OP_QADD, 32'h80000000, 32'h80000000));
    runOp(makeReq(OP_QSUB, 32'h7fffffff, 32'hffffffff));
    for (i = 0; i < 10; i++) begin
      runOp(makeReq(i[0] ? OP_QSUB : OP_QADD, randBits(32), randBits(32)));
    end
  endtask

  task automatic logicTest();
    aluOp_e ops[14] = '{OP_AND, OP_BIC, OP_ORR, OP_ORN, OP_EOR, OP_EON, OP_TST,
                        OP_TEQ, OP_MOV, OP_LSL, OP_LSR, OP_ASR, OP_ROR, OP_RRX};
    logic [4:0] amts[3] = '{5'd0, 5'd1, 5'd31};
    aluReq_t r;
    logic [31:0] bit1;
    int i;
    int k;
    for (i = 0; i < 14; i++) begin
      for (k = 0; k < 4; k++) begin
        r = makeReq(ops[i], randBits(32), randBits(32));
        // Last pass keeps a random shift amount
        if (k < 3) r.b[4:0] = amts[k];
        bit1 = randBits(1);
        r.carryIn = bit1[0];
        runOp(r);
      end
    end
    runOp(makeReq(OP_AND, 32'hf0f0f0f0, 32'h0f0f0f0f));
    runOp(makeReq(OP_ASR, 32'h80000001, 32'd31));
    runOp(makeReq(OP_LSR, 32'h00000001, 32'd1));
  endtask

  task automatic macTest();
    aluOp_e ops[7] = '{OP_MUL, OP_MLA, OP_MLS, OP_UMULL, OP_UMLAL, OP_SMULL, OP_SMLAL};
    aluReq_t r;
    int i;
    int k;
    for (i = 0; i < 7; i++) begin
      for (k = 0; k < 5; k++) begin
        r = makeReq(ops[i], randBits(32), randBits(32));
        r.accLo = randBits(32);
        r.accHi = randBits(32);
        runOp(r);
      end
    end
    runOp(makeReq(OP_SMULL, 32'hffffffff, 32'h1));
    runOp(makeReq(OP_UMULL, 32'h0, 32'h12345678));
    // Accumulator of minus six cancels the product
    r = makeReq(OP_SMLAL, 32'h2, 32'h3);
    r.accLo = 32'hfffffffa;
    r.accHi = 32'hffffffff;
    runOp(r);
  endtask

  task automatic divTest();
    int i;
    runOp(makeReq(OP_UDIV, 32'd100, 32'd7));
    runOp(makeReq(OP_UDIV, 32'hffffffff, 32'h1));
    runOp(makeReq(OP_UDIV, 32'h12345678, 32'h0));
    runOp(makeReq(OP_SDIV, 32'hffffff9c, 32'd7));
    runOp(makeReq(OP_SDIV, 32'd100, 32'hfffffff9));
    runOp(makeReq(OP_SDIV, 32'hffffff9c, 32'hfffffff9));
    runOp(makeReq(OP_SDIV, 32'd5, 32'h0));
    runOp(makeReq(OP_SDIV, 32'd3, 32'd7));
    for (i = 0; i < 8; i++) begin
      runOp(makeReq(i[0] ? OP_SDIV : OP_UDIV, randBits(32), randBits(32) >> (i * 3)));
    end
  endtask

  initial begin
    rst = 1'b1;
    start = 1'b0;
    req = '0;
    lfsrState = 32'hb907;
    errors = 0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    resetTest();
    addSubTest();
    satTest();
    logicTest();
    macTest();
    divTest();
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
